//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and basic types
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // machine CSR addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MIP       = 12'h344;
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // RV32 with I, M and U
    localparam word_t MISA_VALUE = 32'h4010_1100;

    ////////////////////////////////////////////////////////////////////////////
    // operations and privilege
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_NONE   = 4'd0,
        OP_CSRRW  = 4'd1,
        OP_CSRRS  = 4'd2,
        OP_CSRRC  = 4'd3,
        OP_CSRRWI = 4'd4,
        OP_CSRRSI = 4'd5,
        OP_CSRRCI = 4'd6,
        OP_ECALL  = 4'd7,
        OP_EBREAK = 4'd8,
        OP_MRET   = 4'd9
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    // bit 2 external, bit 1 software, bit 0 timer
    typedef logic [2:0] irq_vec_t;

    localparam int IRQ_EXT = 2;
    localparam int IRQ_SW  = 1;
    localparam int IRQ_TIM = 0;

    // exception and interrupt codes
    localparam logic [30:0] CAUSE_ILLEGAL   = 31'd2;
    localparam logic [30:0] CAUSE_BREAK     = 31'd3;
    localparam logic [30:0] CAUSE_ECALL_U   = 31'd8;
    localparam logic [30:0] CAUSE_ECALL_M   = 31'd11;
    localparam logic [30:0] CAUSE_IRQ_SW    = 31'd3;
    localparam logic [30:0] CAUSE_IRQ_TIMER = 31'd7;
    localparam logic [30:0] CAUSE_IRQ_EXT   = 31'd11;

    // enable and pending positions in mie / mip
    localparam int BIT_MSI = 3;
    localparam int BIT_MTI = 7;
    localparam int BIT_MEI = 11;

    // mstatus fields
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

endpackage

`default_nettype wire

//--- source/csr_counters.sv
`default_nettype none

module csr_counters (
    input  wire logic          CLK,
    input  wire logic          RST,
    input  wire logic          count_instret,
    input  wire csr_pkg::word_t wdata,
    input  wire logic          cycle_lo_we,
    input  wire logic          cycle_hi_we,
    input  wire logic          instret_lo_we,
    input  wire logic          instret_hi_we,
    output logic [63:0]        cycle,
    output logic [63:0]        instret
);

    // a half-word load wins over the increment
    function automatic logic [63:0] next_count(
        input logic [63:0] cur,
        input logic        lo_we,
        input logic        hi_we,
        input logic        inc,
        input logic [31:0] data
    );
        logic [63:0] nxt;
        nxt = cur;
        if (lo_we)
        begin
            nxt[31:0] = data;
        end
        else if (hi_we)
        begin
            nxt[63:32] = data;
        end
        else if (inc)
        begin
            nxt = cur + 64'd1;
        end
        return nxt;
    endfunction

    // cycle counts every edge out of reset
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            cycle   <= '0;
            instret <= '0;
        end
        else
        begin
            cycle   <= next_count(cycle, cycle_lo_we, cycle_hi_we, 1'b1, wdata);
            instret <= next_count(instret, instret_lo_we, instret_hi_we,
                                  count_instret, wdata);
        end
    end

endmodule

`default_nettype wire

//--- source/trap_ctrl.sv
`default_nettype none

module trap_ctrl (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic              retire,
    input  wire csr_pkg::csr_op_e  op,
    input  wire csr_pkg::word_t    pc,
    input  wire csr_pkg::irq_vec_t irq_pending,
    input  wire csr_pkg::irq_vec_t irq_enable,
    input  wire logic              illegal,
    input  wire csr_pkg::word_t    wdata,
    input  wire logic              mstatus_we,
    input  wire logic              mepc_we,
    input  wire logic              mcause_we,
    input  wire csr_pkg::word_t    mtvec,
    output logic                   trap_taken,
    output logic                   jump,
    output csr_pkg::word_t         jump_addr,
    output csr_pkg::word_t         mstatus,
    output csr_pkg::word_t         mepc,
    output csr_pkg::word_t         mcause,
    output csr_pkg::priv_e         priv
);

    import csr_pkg::*;

    logic        mie_q;
    logic        mpie_q;
    priv_e       mpp_q;
    irq_vec_t    irq_hit;
    logic        irq_taken;
    logic        exc_taken;
    logic        mret_go;
    logic        cause_irq;
    logic [30:0] cause_code;

    ////////////////////////////////////////////////////////////////////////////
    // trap decision
    ////////////////////////////////////////////////////////////////////////////

    // interrupts are taken on a retiring slot so pc is valid for mepc
    assign irq_hit    = irq_pending & irq_enable;
    assign irq_taken  = retire & mie_q & (|irq_hit);
    assign exc_taken  = illegal | (retire & ((op == OP_ECALL) | (op == OP_EBREAK)));
    assign trap_taken = irq_taken | exc_taken;
    assign mret_go    = retire & (op == OP_MRET) & ~irq_taken;

    assign jump      = trap_taken | mret_go;
    // direct mode only, mode bits are ignored
    assign jump_addr = trap_taken ? {mtvec[31:2], 2'b00} : mepc;

    // external over software over timer, any interrupt over exceptions
    always_comb
    begin
        cause_irq  = 1'b0;
        cause_code = '0;
        if (irq_taken)
        begin
            cause_irq = 1'b1;
            if (irq_hit[IRQ_EXT])
                cause_code = CAUSE_IRQ_EXT;
            else if (irq_hit[IRQ_SW])
                cause_code = CAUSE_IRQ_SW;
            else
                cause_code = CAUSE_IRQ_TIMER;
        end
        else if (illegal)
            cause_code = CAUSE_ILLEGAL;
        else if (op == OP_EBREAK)
            cause_code = CAUSE_BREAK;
        else if (op == OP_ECALL)
            cause_code = (priv == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    end

    always_comb
    begin
        mstatus = '0;
        mstatus[MSTATUS_MIE]                   = mie_q;
        mstatus[MSTATUS_MPIE]                  = mpie_q;
        mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mpp_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            priv   <= PRIV_M;
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
            mpp_q  <= PRIV_M;
            mepc   <= '0;
            mcause <= '0;
        end
        else if (trap_taken)
        begin
            mepc   <= pc;
            mcause <= {cause_irq, cause_code};
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
            mpp_q  <= priv;
            priv   <= PRIV_M;
        end
        else if (mret_go)
        begin
            priv   <= mpp_q;
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
            mpp_q  <= PRIV_U;
        end
        else
        begin
            if (mstatus_we)
            begin
                mie_q  <= wdata[MSTATUS_MIE];
                mpie_q <= wdata[MSTATUS_MPIE];
                // only U and M exist, anything but 11 means user
                mpp_q  <= (wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == 2'b11) ? PRIV_M : PRIV_U;
            end
            if (mepc_we)
                mepc <= wdata;
            if (mcause_we)
                mcause <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- source/csr_regs.sv
`default_nettype none

module csr_regs (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire logic               retire,
    input  wire csr_pkg::csr_op_e   op,
    input  wire csr_pkg::csr_addr_t csr_addr,
    input  wire logic [4:0]         rs1_idx,
    input  wire csr_pkg::word_t     rs1_data,
    input  wire csr_pkg::irq_vec_t  irq_pending,
    input  wire csr_pkg::priv_e     priv,
    input  wire logic               trap_taken,
    input  wire csr_pkg::word_t     mstatus,
    input  wire csr_pkg::word_t     mepc,
    input  wire csr_pkg::word_t     mcause,
    input  wire logic [63:0]        cycle,
    input  wire logic [63:0]        instret,
    output csr_pkg::word_t          rdata,
    output csr_pkg::word_t          wdata,
    output csr_pkg::word_t          mtvec,
    output csr_pkg::irq_vec_t       irq_enable,
    output logic                    illegal,
    output logic                    mstatus_we,
    output logic                    mepc_we,
    output logic                    mcause_we,
    output logic                    cycle_lo_we,
    output logic                    cycle_hi_we,
    output logic                    instret_lo_we,
    output logic                    instret_hi_we
);

    import csr_pkg::*;

    word_t mscratch;
    word_t imm;
    word_t mie_word;
    word_t mip_word;
    logic  is_csr_op;
    logic  is_set_clr;
    logic  write_go;
    logic  mtvec_we;
    logic  mscratch_we;
    logic  mie_we;

    ////////////////////////////////////////////////////////////////////////////
    // decode and access check
    ////////////////////////////////////////////////////////////////////////////

    assign is_csr_op  = op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                   OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    assign is_set_clr = op inside {OP_CSRRS, OP_CSRRC, OP_CSRRSI, OP_CSRRCI};

    // address bits 9:8 hold the lowest privilege allowed
    assign illegal = retire & is_csr_op & (2'(priv) < csr_addr[9:8]);

    // set and clear with x0 / zero immediate are pure reads
    assign write_go = retire & is_csr_op & ~trap_taken
                    & ~(is_set_clr & (rs1_idx == 5'd0));

    assign imm = {27'd0, rs1_idx};

    ////////////////////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        mie_word = '0;
        mie_word[BIT_MEI] = irq_enable[IRQ_EXT];
        mie_word[BIT_MSI] = irq_enable[IRQ_SW];
        mie_word[BIT_MTI] = irq_enable[IRQ_TIM];
        mip_word = '0;
        mip_word[BIT_MEI] = irq_pending[IRQ_EXT];
        mip_word[BIT_MSI] = irq_pending[IRQ_SW];
        mip_word[BIT_MTI] = irq_pending[IRQ_TIM];
    end

    always_comb
    begin
        case (csr_addr)
            CSR_MSTATUS:   rdata = mstatus;
            CSR_MISA:      rdata = MISA_VALUE;
            CSR_MIE:       rdata = mie_word;
            CSR_MTVEC:     rdata = mtvec;
            CSR_MSCRATCH:  rdata = mscratch;
            CSR_MEPC:      rdata = mepc;
            CSR_MCAUSE:    rdata = mcause;
            CSR_MIP:       rdata = mip_word;
            CSR_MCYCLE:    rdata = cycle[31:0];
            CSR_MINSTRET:  rdata = instret[31:0];
            CSR_MCYCLEH:   rdata = cycle[63:32];
            CSR_MINSTRETH: rdata = instret[63:32];
            CSR_MHARTID:   rdata = '0;
            default:       rdata = '0;
        endcase
    end

    // new value from the old one read in this cycle
    always_comb
    begin
        case (op)
            OP_CSRRW:  wdata = rs1_data;
            OP_CSRRS:  wdata = rdata | rs1_data;
            OP_CSRRC:  wdata = rdata & ~rs1_data;
            OP_CSRRWI: wdata = imm;
            OP_CSRRSI: wdata = rdata | imm;
            OP_CSRRCI: wdata = rdata & ~imm;
            default:   wdata = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // write strobes and local storage
    ////////////////////////////////////////////////////////////////////////////

    assign mstatus_we    = write_go & (csr_addr == CSR_MSTATUS);
    assign mepc_we       = write_go & (csr_addr == CSR_MEPC);
    assign mcause_we     = write_go & (csr_addr == CSR_MCAUSE);
    assign cycle_lo_we   = write_go & (csr_addr == CSR_MCYCLE);
    assign cycle_hi_we   = write_go & (csr_addr == CSR_MCYCLEH);
    assign instret_lo_we = write_go & (csr_addr == CSR_MINSTRET);
    assign instret_hi_we = write_go & (csr_addr == CSR_MINSTRETH);
    assign mtvec_we      = write_go & (csr_addr == CSR_MTVEC);
    assign mscratch_we   = write_go & (csr_addr == CSR_MSCRATCH);
    assign mie_we        = write_go & (csr_addr == CSR_MIE);

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            mtvec      <= '0;
            mscratch   <= '0;
            irq_enable <= '0;
        end
        else
        begin
            // mode bits are kept for readback only
            if (mtvec_we)
                mtvec <= wdata;
            if (mscratch_we)
                mscratch <= wdata;
            if (mie_we)
            begin
                irq_enable[IRQ_EXT] <= wdata[BIT_MEI];
                irq_enable[IRQ_SW]  <= wdata[BIT_MSI];
                irq_enable[IRQ_TIM] <= wdata[BIT_MTI];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire logic               retire,
    input  wire csr_pkg::csr_op_e   op,
    input  wire csr_pkg::csr_addr_t csr_addr,
    input  wire logic [4:0]         rs1_idx,
    input  wire csr_pkg::word_t     rs1_data,
    input  wire csr_pkg::word_t     pc,
    input  wire csr_pkg::irq_vec_t  irq_pending,
    output csr_pkg::word_t          rdata,
    output logic                    trap_taken,
    output logic                    jump,
    output csr_pkg::word_t          jump_addr,
    output csr_pkg::priv_e          priv
);

    import csr_pkg::*;

    word_t       wdata;
    word_t       mtvec;
    word_t       mstatus;
    word_t       mepc;
    word_t       mcause;
    irq_vec_t    irq_enable;
    logic        illegal;
    logic        mstatus_we;
    logic        mepc_we;
    logic        mcause_we;
    logic        cycle_lo_we;
    logic        cycle_hi_we;
    logic        instret_lo_we;
    logic        instret_hi_we;
    logic        count_instret;
    logic [63:0] cycle;
    logic [63:0] instret;

    // a trapping instruction does not retire
    assign count_instret = retire & ~trap_taken;

    csr_regs u_regs (
        .CLK           (CLK),
        .RST           (RST),
        .retire        (retire),
        .op            (op),
        .csr_addr      (csr_addr),
        .rs1_idx       (rs1_idx),
        .rs1_data      (rs1_data),
        .irq_pending   (irq_pending),
        .priv          (priv),
        .trap_taken    (trap_taken),
        .mstatus       (mstatus),
        .mepc          (mepc),
        .mcause        (mcause),
        .cycle         (cycle),
        .instret       (instret),
        .rdata         (rdata),
        .wdata         (wdata),
        .mtvec         (mtvec),
        .irq_enable    (irq_enable),
        .illegal       (illegal),
        .mstatus_we    (mstatus_we),
        .mepc_we       (mepc_we),
        .mcause_we     (mcause_we),
        .cycle_lo_we   (cycle_lo_we),
        .cycle_hi_we   (cycle_hi_we),
        .instret_lo_we (instret_lo_we),
        .instret_hi_we (instret_hi_we)
    );

    trap_ctrl u_trap (
        .CLK         (CLK),
        .RST         (RST),
        .retire      (retire),
        .op          (op),
        .pc          (pc),
        .irq_pending (irq_pending),
        .irq_enable  (irq_enable),
        .illegal     (illegal),
        .wdata       (wdata),
        .mstatus_we  (mstatus_we),
        .mepc_we     (mepc_we),
        .mcause_we   (mcause_we),
        .mtvec       (mtvec),
        .trap_taken  (trap_taken),
        .jump        (jump),
        .jump_addr   (jump_addr),
        .mstatus     (mstatus),
        .mepc        (mepc),
        .mcause      (mcause),
        .priv        (priv)
    );

    csr_counters u_counters (
        .CLK           (CLK),
        .RST           (RST),
        .count_instret (count_instret),
        .wdata         (wdata),
        .cycle_lo_we   (cycle_lo_we),
        .cycle_hi_we   (cycle_hi_we),
        .instret_lo_we (instret_lo_we),
        .instret_hi_we (instret_hi_we),
        .cycle         (cycle),
        .instret       (instret)
    );

endmodule

`default_nettype wire

//--- test/csr_unit_sva.sv
`default_nettype none

module csr_unit_sva (
    input  wire logic           CLK,
    input  wire logic           RST,
    input  wire logic           trap_taken,
    input  wire logic           jump,
    input  wire csr_pkg::word_t jump_addr,
    input  wire csr_pkg::priv_e priv
);

    import csr_pkg::*;

    // a trap always redirects the core
    trap_implies_jump: assert property (
        @(posedge CLK) disable iff (RST)
        trap_taken |-> jump
    ) else $error("trap_taken high without jump");

    // trap entry lands in machine mode
    trap_enters_machine: assert property (
        @(posedge CLK) disable iff (RST)
        trap_taken |=> (priv == PRIV_M)
    ) else $error("privilege is not machine one cycle after a trap");

    // direct mode target, word aligned
    trap_target_aligned: assert property (
        @(posedge CLK) disable iff (RST)
        trap_taken |-> (jump_addr[1:0] == 2'b00)
    ) else $error("trap jump_addr has low bits set");

endmodule

bind trap_ctrl csr_unit_sva sva (
    .CLK        (CLK),
    .RST        (RST),
    .trap_taken (trap_taken),
    .jump       (jump),
    .jump_addr  (jump_addr),
    .priv       (priv)
);

`default_nettype wire

//--- test/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    // one trace line, stimulus first and expected values after
    typedef struct packed {
        logic      retire;
        logic [3:0] op;
        csr_addr_t addr;
        logic [4:0] rs1_idx;
        word_t     rs1_data;
        word_t     pc;
        irq_vec_t  irq;
        word_t     rdata;
        logic      trap;
        logic      jump;
        word_t     jump_addr;
        logic [1:0] priv;
    } trace_line_t;

    logic        CLK;
    logic        RST;
    logic        retire;
    csr_op_e     op;
    csr_addr_t   csr_addr;
    logic [4:0]  rs1_idx;
    word_t       rs1_data;
    word_t       pc;
    irq_vec_t    irq_pending;
    word_t       rdata;
    logic        trap_taken;
    logic        jump;
    word_t       jump_addr;
    priv_e       priv;

    trace_line_t trace_q[$];
    int          n_checks;
    int          n_errors;
    int          limit;
    int          cycle_count;

    csr_unit dut (
        .CLK         (CLK),
        .RST         (RST),
        .retire      (retire),
        .op          (op),
        .csr_addr    (csr_addr),
        .rs1_idx     (rs1_idx),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .irq_pending (irq_pending),
        .rdata       (rdata),
        .trap_taken  (trap_taken),
        .jump        (jump),
        .jump_addr   (jump_addr),
        .priv        (priv)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_priv(input string what, input priv_e got, input priv_e exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // trace reading, drive and check
    ////////////////////////////////////////////////////////////////////////////

    // lines starting with # are column notes
    task automatic load_trace();
        int          fd;
        int          code;
        string       text;
        logic [31:0] v_ret, v_op, v_addr, v_idx, v_data, v_pc;
        logic [31:0] v_irq, v_rdata, v_trap, v_jump, v_jaddr, v_priv;
        trace_line_t t;
        fd = $fopen("test/csr_unit_trace.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd))
        begin
            code = $fgets(text, fd);
            if (code > 0 && text.len() > 1 && text.getc(0) != "#")
            begin
                code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
                               v_ret, v_op, v_addr, v_idx, v_data, v_pc,
                               v_irq, v_rdata, v_trap, v_jump, v_jaddr, v_priv);
                if (code == 12)
                begin
                    t.retire    = v_ret[0];
                    t.op        = v_op[3:0];
                    t.addr      = v_addr[11:0];
                    t.rs1_idx   = v_idx[4:0];
                    t.rs1_data  = v_data;
                    t.pc        = v_pc;
                    t.irq       = v_irq[2:0];
                    t.rdata     = v_rdata;
                    t.trap      = v_trap[0];
                    t.jump      = v_jump[0];
                    t.jump_addr = v_jaddr;
                    t.priv      = v_priv[1:0];
                    trace_q.push_back(t);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_line(input trace_line_t t);
        retire      = t.retire;
        op          = csr_op_e'(t.op);
        csr_addr    = t.addr;
        rs1_idx     = t.rs1_idx;
        rs1_data    = t.rs1_data;
        pc          = t.pc;
        irq_pending = t.irq;
    endtask

    // jump_addr only means something when a jump is expected
    task automatic check_line(input trace_line_t t, input int idx);
        check_word($sformatf("line %0d rdata", idx), rdata, t.rdata);
        check_flag($sformatf("line %0d trap_taken", idx), trap_taken, t.trap);
        check_flag($sformatf("line %0d jump", idx), jump, t.jump);
        if (t.jump)
            check_word($sformatf("line %0d jump_addr", idx), jump_addr, t.jump_addr);
        check_priv($sformatf("line %0d priv", idx), priv, priv_e'(t.priv));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        RST         = 1'b1;
        retire      = 1'b0;
        op          = OP_NONE;
        csr_addr    = '0;
        rs1_idx     = '0;
        rs1_data    = '0;
        pc          = '0;
        irq_pending = '0;
        n_checks    = 0;
        n_errors    = 0;
        limit       = 0;
        load_trace();
        if (trace_q.size() == 0)
        begin
            $display("Trace file test/csr_unit_trace.txt is missing or holds no lines");
            $display("CHECKS FAILED");
            $finish;
        end
        else
        begin
            limit = 2 * trace_q.size() + 20;
            repeat (3) @(posedge CLK);
            #10;
            RST = 1'b0;
            foreach (trace_q[i])
            begin
                drive_line(trace_q[i]);
                #70;
                check_line(trace_q[i], i);
                @(posedge CLK);
                #10;
            end
            $display("%0d trace lines, %0d checks, %0d errors",
                     trace_q.size(), n_checks, n_errors);
            if (n_errors == 0)
                $display("ALL CHECKS PASSED");
            else
                $display("CHECKS FAILED");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        cycle_count = 0;
        wait (limit > 0);
        while (cycle_count < limit)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: the trace did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/csr_unit_trace.txt
# stimulus: retire op csr_addr rs1_idx rs1_data pc irq_pending (hex)
# expected: rdata trap_taken jump jump_addr priv (hex)
1 1 340 01 a5a50f0f 00000000 0 00000000 0 0 00000000 3
1 2 340 02 0000f000 00000000 0 a5a50f0f 0 0 00000000 3
1 3 340 03 a000000f 00000000 0 a5a5ff0f 0 0 00000000 3
1 2 340 00 ffffffff 00000000 0 05a5ff00 0 0 00000000 3
1 3 340 00 ffffffff 00000000 0 05a5ff00 0 0 00000000 3
1 4 305 15 00000000 00000000 0 00000000 0 0 00000000 3
1 5 305 0a 00000000 00000000 0 00000015 0 0 00000000 3
1 6 305 03 00000000 00000000 0 0000001f 0 0 00000000 3
1 5 305 00 00000000 00000000 0 0000001c 0 0 00000000 3
1 6 305 00 00000000 00000000 0 0000001c 0 0 00000000 3
1 1 305 05 00000203 00000000 0 0000001c 0 0 00000000 3
1 2 305 00 00000000 00000000 0 00000203 0 0 00000000 3
1 2 340 00 00000000 00000000 0 05a5ff00 0 0 00000000 3
1 7 000 00 00000000 00001040 0 00000000 1 1 00000200 3
1 2 342 00 00000000 00000000 0 0000000b 0 0 00000000 3
1 2 341 00 00000000 00000000 0 00001040 0 0 00000000 3
1 8 000 00 00000000 00001050 0 00000000 1 1 00000200 3
1 2 342 00 00000000 00000000 0 00000003 0 0 00000000 3
1 9 000 00 00000000 00000000 0 00000000 0 1 00001050 3
1 2 300 00 00000000 00000000 0 00000080 0 0 00000000 3
1 1 300 01 00000000 00000000 0 00000080 0 0 00000000 3
1 1 341 01 00002000 00000000 0 00001050 0 0 00000000 3
1 9 000 00 00000000 00000000 0 00000000 0 1 00002000 3
1 1 340 01 deadbeef 00002000 0 05a5ff00 1 1 00000200 0
1 2 342 00 00000000 00000000 0 00000002 0 0 00000000 3
1 2 340 00 00000000 00000000 0 05a5ff00 0 0 00000000 3
1 9 000 00 00000000 00000000 0 00000000 0 1 00002000 3
1 0 000 00 00000000 00000000 0 00000000 0 0 00000000 0
1 7 000 00 00000000 00002004 0 00000000 1 1 00000200 0
1 2 342 00 00000000 00000000 0 00000008 0 0 00000000 3
1 2 300 00 00000000 00000000 0 00000000 0 0 00000000 3
1 1 304 01 00000880 00000000 0 00000000 0 0 00000000 3
1 0 344 00 00000000 00000000 5 00000880 0 0 00000000 3
1 5 300 08 00000000 00000000 0 00000000 0 0 00000000 3
1 0 344 00 00000000 00003000 5 00000880 1 1 00000200 3
1 2 342 00 00000000 00000000 0 8000000b 0 0 00000000 3
1 2 300 00 00000000 00000000 0 00001880 0 0 00000000 3
1 5 300 08 00000000 00000000 0 00001880 0 0 00000000 3
1 0 000 00 00000000 00003010 1 00000000 1 1 00000200 3
1 2 342 00 00000000 00000000 0 80000007 0 0 00000000 3
1 2 b00 00 00000000 00000000 0 00000028 0 0 00000000 3
1 1 b00 01 00001000 00000000 0 00000029 0 0 00000000 3
1 0 000 00 00000000 00000000 0 00000000 0 0 00000000 3
1 0 000 00 00000000 00000000 0 00000000 0 0 00000000 3
1 2 b00 00 00000000 00000000 0 00001002 0 0 00000000 3
1 2 b02 00 00000000 00000000 0 00000027 0 0 00000000 3
0 0 000 00 00000000 00000000 0 00000000 0 0 00000000 3
1 7 000 00 00000000 00004000 0 00000000 1 1 00000200 3
1 0 000 00 00000000 00000000 0 00000000 0 0 00000000 3
1 2 b02 00 00000000 00000000 0 00000029 0 0 00000000 3
1 2 b80 00 00000000 00000000 0 00000000 0 0 00000000 3
1 1 b80 01 00000055 00000000 0 00000000 0 0 00000000 3
1 2 b80 00 00000000 00000000 0 00000055 0 0 00000000 3
1 2 b00 00 00000000 00000000 0 0000100a 0 0 00000000 3
1 2 301 00 00000000 00000000 0 40101100 0 0 00000000 3
1 1 301 01 00000000 00000000 0 40101100 0 0 00000000 3
1 2 301 00 00000000 00000000 0 40101100 0 0 00000000 3
1 2 f14 00 00000000 00000000 0 00000000 0 0 00000000 3
1 2 7c0 00 00000000 00000000 0 00000000 0 0 00000000 3
1 2 b02 00 00000000 00000000 0 00000033 0 0 00000000 3

//--- csr_unit.f
source/csr_pkg.sv
source/csr_counters.sv
source/trap_ctrl.sv
source/csr_regs.sv
source/csr_unit.sv
test/csr_unit_sva.sv
test/csr_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = csr_unit_tb
FILELIST  = csr_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
